/* logic/cache_pkg.sv */
// Shared widths and types of the data cache.
// Geometry beyond the line layout (ways, sets) comes in through
// module parameters set at the top level.

`default_nettype none

package cache_pkg;

    // Address and data widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // Line layout
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W = WORD_W * WORDS_PER_LINE;

    // Byte offset within one line
    localparam int OFFSET_W = $clog2(LINE_W / 8);

    // One data word
    typedef logic [WORD_W-1:0] word_t;

    // Word 0 sits in the low bits of the line
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    // Full byte address, tag above index above offset
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

/* logic/way_if.sv */
// Bundle between the controller, one cache way and the merge unit.
// The controller drives the lookup and the write commands, the way
// answers with its entry at the current index.

`default_nettype none

interface way_if #(
    parameter int SETS = 16
);
    import cache_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    // Lookup and write commands
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    line_t              write_line;
    logic               store_en;
    logic               fill_en;

    // Entry of the way at index
    logic               hit;
    line_t              line;
    logic [TAG_W-1:0]   line_tag;
    logic               valid;
    logic               dirty;

    modport ctrl (
        output index, tag, write_line, store_en, fill_en,
        input  hit, line, line_tag, valid, dirty
    );

    modport way (
        input  index, tag, write_line, store_en, fill_en,
        output hit, line, line_tag, valid, dirty
    );

    modport merge (
        input  index, hit, line, line_tag, valid, dirty
    );

endinterface

`default_nettype wire

/* logic/cache_way.sv */
// One way of the set-associative cache.
// Holds tag, line, valid and dirty per set. The entry at the bus index
// is read combinationally, writes from the controller land at the edge.

`default_nettype none

module cache_way #(
    parameter int SETS = 16
) (
    input  logic clk,
    input  logic rst_n,
    way_if.way   bus
);
    import cache_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    // Storage arrays
    logic [TAG_W-1:0] tag_mem  [SETS];
    line_t            line_mem [SETS];
    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;

    // Read side
    assign bus.line     = line_mem[bus.index];
    assign bus.line_tag = tag_mem[bus.index];
    assign bus.valid    = valid_q[bus.index];
    assign bus.dirty    = dirty_q[bus.index];

    // Hit needs both the valid bit and a matching tag
    assign bus.hit = valid_q[bus.index] && (tag_mem[bus.index] == bus.tag);

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (bus.fill_en) begin
            tag_mem[bus.index]  <= bus.tag;
            line_mem[bus.index] <= bus.write_line;
        end else if (bus.store_en) begin
            // Tag stays, only the line changes
            line_mem[bus.index] <= bus.write_line;
        end
    end

    // Status bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (bus.fill_en) begin
                valid_q[bus.index] <= 1'b1;
                dirty_q[bus.index] <= 1'b0;
            end else if (bus.store_en) begin
                dirty_q[bus.index] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cache_ctrl.sv */
// Request side of the blocking data cache.
// Accepts one request at a time, serves hits at once and runs a miss
// through L2 request, refill and replay. Drives lookup and write
// commands to every way and a touch pulse to the LRU logic.

`default_nettype none

module cache_ctrl #(
    parameter int WAYS = 4,
    parameter int SETS = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  logic               req_store,
    input  cache_pkg::addr_t   req_addr,
    input  cache_pkg::word_t   req_wdata,
    input  logic               fill_valid,
    input  cache_pkg::addr_t   fill_addr,
    input  cache_pkg::line_t   fill_data,
    input  logic               hit,
    input  cache_pkg::line_t   hit_line,
    input  logic [WAYS-1:0]    victim_way,
    output logic               blocked,
    output logic               resp_valid,
    output cache_pkg::word_t   resp_data,
    output logic               l2_req_valid,
    output cache_pkg::addr_t   l2_req_addr,
    output logic               touch,
    way_if.ctrl                ways [WAYS]
);
    import cache_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WSEL_W  = $clog2(WORDS_PER_LINE);

    typedef enum logic [1:0] {IDLE, MISS, REPLAY} state_t;

    state_t             state_q;
    logic               pend_store;
    addr_t              pend_addr;
    word_t              pend_wdata;
    addr_t              look_addr;
    word_t              look_wdata;
    logic [WSEL_W-1:0]  wsel;
    line_t              store_line;
    logic               accept;
    logic               miss_go;
    logic               fill_go;
    logic               load_go;
    logic               store_go;

    assign blocked = (state_q != IDLE);
    assign accept  = (state_q == IDLE) && req_valid;
    assign miss_go = accept && !hit;
    assign fill_go = (state_q == MISS) && fill_valid;

    // Replay always hits, so it needs no hit term
    assign load_go  = (accept && hit && !req_store) || (state_q == REPLAY && !pend_store);
    assign store_go = (accept && hit && req_store) || (state_q == REPLAY && pend_store);
    assign touch    = load_go || store_go;

    // Lookup source per state
    always_comb begin
        look_addr  = req_addr;
        look_wdata = req_wdata;
        if (state_q == MISS) begin
            look_addr = fill_addr;
        end else if (state_q == REPLAY) begin
            look_addr  = pend_addr;
            look_wdata = pend_wdata;
        end
    end

    assign wsel = look_addr[OFFSET_W-1 -: WSEL_W];

    // Hit line with the store word merged in
    always_comb begin
        store_line       = hit_line;
        store_line[wsel] = look_wdata;
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_cmd
        assign ways[w].index      = look_addr[OFFSET_W +: INDEX_W];
        assign ways[w].tag        = look_addr[ADDR_W-1 -: TAG_W];
        assign ways[w].write_line = fill_go ? fill_data : store_line;
        assign ways[w].store_en   = store_go && ways[w].hit;
        assign ways[w].fill_en    = fill_go && victim_way[w];
    end

    // FSM and one-cycle strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            resp_valid   <= 1'b0;
            l2_req_valid <= 1'b0;
        end else begin
            resp_valid   <= load_go;
            l2_req_valid <= miss_go;
            case (state_q)
                IDLE:    if (miss_go) state_q <= MISS;
                MISS:    if (fill_valid) state_q <= REPLAY;
                REPLAY:  state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Response word, L2 address and the held request
    always_ff @(posedge clk) begin
        if (load_go) begin
            resp_data <= hit_line[wsel];
        end
        if (miss_go) begin
            pend_store  <= req_store;
            pend_addr   <= req_addr;
            pend_wdata  <= req_wdata;
            l2_req_addr <= {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

endmodule

`default_nettype wire

/* logic/way_merge.sv */
// Combines the answers of all ways.
// Selects the hit line, keeps LRU ages per set, picks the refill
// victim and forms the write-back of a dirty victim during a fill.

`default_nettype none

module way_merge #(
    parameter int WAYS = 4,
    parameter int SETS = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    way_if.merge              ways [WAYS],
    input  logic              touch,
    input  logic              fill_valid,
    output logic              hit,
    output cache_pkg::line_t  hit_line,
    output logic [WAYS-1:0]   victim_way,
    output logic              wb_valid,
    output cache_pkg::addr_t  wb_addr,
    output cache_pkg::line_t  wb_data
);
    import cache_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;
    localparam int AGE_W   = $clog2(WAYS);

    logic [WAYS-1:0]    hit_vec;
    logic [WAYS-1:0]    valid_vec;
    logic [WAYS-1:0]    dirty_vec;
    line_t              lines [WAYS];
    logic [TAG_W-1:0]   tags  [WAYS];
    logic [INDEX_W-1:0] idx;
    logic [AGE_W-1:0]   age_q [SETS][WAYS];
    logic [AGE_W-1:0]   hit_age;
    logic               free_found;
    line_t              victim_line;
    logic [TAG_W-1:0]   victim_tag;
    logic               victim_valid;
    logic               victim_dirty;

    for (genvar w = 0; w < WAYS; w++) begin : g_collect
        assign hit_vec[w]   = ways[w].hit;
        assign valid_vec[w] = ways[w].valid;
        assign dirty_vec[w] = ways[w].dirty;
        assign lines[w]     = ways[w].line;
        assign tags[w]      = ways[w].line_tag;
    end

    // All ways see the same index
    assign idx = ways[0].index;
    assign hit = |hit_vec;

    // At most one way hits, so an AND-OR mux is enough
    always_comb begin
        hit_line = '0;
        hit_age  = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_line = hit_line | (lines[w] & {LINE_W{hit_vec[w]}});
            hit_age  = hit_age | (age_q[idx][w] & {AGE_W{hit_vec[w]}});
        end
    end

    // Lowest invalid way first, else the oldest
    always_comb begin
        victim_way = '0;
        free_found = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (!valid_vec[w] && !free_found) begin
                victim_way[w] = 1'b1;
                free_found    = 1'b1;
            end
        end
        if (!free_found) begin
            for (int w = 0; w < WAYS; w++) begin
                victim_way[w] = (age_q[idx][w] == AGE_W'(WAYS - 1));
            end
        end
    end

    always_comb begin
        victim_line  = '0;
        victim_tag   = '0;
        victim_valid = 1'b0;
        victim_dirty = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            victim_line  = victim_line | (lines[w] & {LINE_W{victim_way[w]}});
            victim_tag   = victim_tag | (tags[w] & {TAG_W{victim_way[w]}});
            victim_valid = victim_valid | (valid_vec[w] & victim_way[w]);
            victim_dirty = victim_dirty | (dirty_vec[w] & victim_way[w]);
        end
    end

    // Write-back goes out alongside the refill
    assign wb_valid = fill_valid && victim_valid && victim_dirty;
    assign wb_addr  = {victim_tag, idx, {OFFSET_W{1'b0}}};
    assign wb_data  = victim_line;

    // Ages form a permutation per set, 0 is youngest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    age_q[s][w] <= AGE_W'(w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < WAYS; w++) begin
                if (hit_vec[w]) begin
                    age_q[idx][w] <= '0;
                end else if (age_q[idx][w] < hit_age) begin
                    age_q[idx][w] <= age_q[idx][w] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/data_cache.sv */
// Top level of the blocking write-back data cache.
// Connects the controller, one storage block per way and the merge
// unit. Requests use valid against blocked, L2 uses plain strobes.

`default_nettype none

module data_cache #(
    parameter int WAYS = 4,
    parameter int SETS = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  logic              req_store,
    input  cache_pkg::addr_t  req_addr,
    input  cache_pkg::word_t  req_wdata,
    input  logic              fill_valid,
    input  cache_pkg::addr_t  fill_addr,
    input  cache_pkg::line_t  fill_data,
    output logic              blocked,
    output logic              resp_valid,
    output cache_pkg::word_t  resp_data,
    output logic              l2_req_valid,
    output cache_pkg::addr_t  l2_req_addr,
    output logic              wb_valid,
    output cache_pkg::addr_t  wb_addr,
    output cache_pkg::line_t  wb_data
);
    import cache_pkg::*;

    logic            hit;
    line_t           hit_line;
    logic [WAYS-1:0] victim_way;
    logic            touch;

    // One bundle per way
    way_if #(.SETS(SETS)) way_bus [WAYS] ();

    cache_ctrl #(
        .WAYS (WAYS),
        .SETS (SETS)
    ) i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_store    (req_store),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data),
        .hit          (hit),
        .hit_line     (hit_line),
        .victim_way   (victim_way),
        .blocked      (blocked),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .l2_req_valid (l2_req_valid),
        .l2_req_addr  (l2_req_addr),
        .touch        (touch),
        .ways         (way_bus)
    );

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        cache_way #(
            .SETS (SETS)
        ) i_way (
            .clk   (clk),
            .rst_n (rst_n),
            .bus   (way_bus[w])
        );
    end

    way_merge #(
        .WAYS (WAYS),
        .SETS (SETS)
    ) i_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .ways       (way_bus),
        .touch      (touch),
        .fill_valid (fill_valid),
        .hit        (hit),
        .hit_line   (hit_line),
        .victim_way (victim_way),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

/* bench/cache_properties.sv */
// Protocol checks on the ports of the data cache.
// Bound to every data_cache instance, reports through failing assertions.

`default_nettype none

module cache_properties (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic blocked,
    input wire logic resp_valid,
    input wire logic l2_req_valid,
    input wire logic fill_valid,
    input wire logic wb_valid
);

    // One L2 request pulse per miss
    l2_req_single: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req_valid |=> !l2_req_valid)
        else $error("l2_req_valid high for two cycles");

    // Write-back rides on the refill
    wb_with_fill: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> fill_valid)
        else $error("wb_valid without fill_valid");

    fill_when_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        fill_valid |-> blocked)
        else $error("fill_valid while not blocked");

    resp_when_free: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> !blocked)
        else $error("resp_valid while blocked");

endmodule

bind data_cache cache_properties i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .blocked      (blocked),
    .resp_valid   (resp_valid),
    .l2_req_valid (l2_req_valid),
    .fill_valid   (fill_valid),
    .wb_valid     (wb_valid)
);

`default_nettype wire

/* bench/cache_tb.sv */
// Testbench for the blocking write-back data cache.
// Runs a table of loads and stores against an L2 memory model and a
// reference model of tags, valid, dirty and LRU ages per set.

`default_nettype none

module cache_tb;
    import cache_pkg::*;

    typedef struct packed {
        logic  st;
        addr_t a;
        word_t d;
    } op_t;

    localparam int N_OPS = 16;
    localparam int NW    = 4;
    localparam int NS    = 16;

    logic  clk;
    logic  rst_n;
    logic  req_valid;
    logic  req_store;
    addr_t req_addr;
    word_t req_wdata;
    logic  fill_valid;
    addr_t fill_addr;
    line_t fill_data;
    logic  blocked;
    logic  resp_valid;
    word_t resp_data;
    logic  l2_req_valid;
    addr_t l2_req_addr;
    logic  wb_valid;
    addr_t wb_addr;
    line_t wb_data;

    integer seed = 32'ha2f634e9;
    line_t  mem [addr_t];
    op_t    ops [N_OPS];

    // Reference state per set and way
    logic [23:0] ref_tag   [NS][NW];
    logic        ref_valid [NS][NW];
    logic        ref_dirty [NS][NW];
    int          ref_age   [NS][NW];
    line_t       ref_line  [NS][NW];

    data_cache i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_store    (req_store),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data),
        .blocked      (blocked),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .l2_req_valid (l2_req_valid),
        .l2_req_addr  (l2_req_addr),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data)
    );

    always #5 clk = ~clk;

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_issue(input string what);
        $display("t=%0t %s", $time, what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // Memory lines appear with random contents on first use
    task automatic fetch_line(input addr_t a, output line_t l);
        if (!mem.exists(a)) begin
            for (int i = 0; i < NW; i++) begin
                mem[a][i] = $random(seed);
            end
        end
        l = mem[a];
    endtask

    // Touched way becomes youngest, younger ways age by one
    task automatic touch_way(input int s, input int w);
        int old;
        old = ref_age[s][w];
        for (int v = 0; v < NW; v++) begin
            if (v == w) begin
                ref_age[s][v] = 0;
            end else if (ref_age[s][v] < old) begin
                ref_age[s][v] = ref_age[s][v] + 1;
            end
        end
    endtask

    task automatic run_op(input op_t op);
        int    idx;
        int    ws;
        int    hw;
        int    vw;
        int    delay;
        int    cnt;
        logic  exp_wb;
        addr_t line_addr;
        line_t fl;
        idx = op.a[7:4];
        ws = op.a[3:2];
        hw = -1;
        vw = -1;
        line_addr = {op.a[31:4], 4'h0};
        for (int w = 0; w < NW; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == op.a[31:8]) begin
                hw = w;
            end
        end
        req_valid = 1'b1;
        req_store = op.st;
        req_addr  = op.a;
        req_wdata = op.d;
        @(negedge clk);
        if (hw >= 0) begin
            req_valid = 1'b0;
            assert (l2_req_valid == 1'b0) else report_value("l2_req_valid", l2_req_valid, 0);
            assert (blocked == 1'b0) else report_value("blocked", blocked, 0);
            assert (resp_valid == !op.st) else report_value("resp_valid", resp_valid, !op.st);
            if (!op.st) begin
                assert (resp_data == ref_line[idx][hw][ws])
                    else report_value("resp_data", resp_data, ref_line[idx][hw][ws]);
            end
        end else begin
            assert (l2_req_valid == 1'b1) else report_value("l2_req_valid", l2_req_valid, 1);
            assert (l2_req_addr == line_addr)
                else report_value("l2_req_addr", l2_req_addr, line_addr);
            assert (blocked == 1'b1) else report_value("blocked", blocked, 1);
            for (int w = NW - 1; w >= 0; w--) begin
                if (!ref_valid[idx][w]) begin
                    vw = w;
                end
            end
            if (vw < 0) begin
                for (int w = 0; w < NW; w++) begin
                    if (ref_age[idx][w] == NW - 1) begin
                        vw = w;
                    end
                end
            end
            exp_wb = ref_valid[idx][vw] && ref_dirty[idx][vw];
            fetch_line(line_addr, fl);
            delay = 1 + ({$random(seed)} % 4);
            // Held request must not be taken again while blocked
            repeat (delay) begin
                @(negedge clk);
                assert (blocked == 1'b1) else report_value("blocked", blocked, 1);
                assert (l2_req_valid == 1'b0) else report_value("l2_req_valid", l2_req_valid, 0);
                assert (resp_valid == 1'b0) else report_value("resp_valid", resp_valid, 0);
            end
            fill_valid = 1'b1;
            fill_addr  = line_addr;
            fill_data  = fl;
            #1;
            assert (wb_valid == exp_wb) else report_value("wb_valid", wb_valid, exp_wb);
            if (exp_wb) begin
                assert (wb_addr == {ref_tag[idx][vw], idx[3:0], 4'h0})
                    else report_value("wb_addr", wb_addr, {ref_tag[idx][vw], idx[3:0], 4'h0});
                assert (wb_data == ref_line[idx][vw])
                    else report_value("wb_data", wb_data, ref_line[idx][vw]);
                mem[wb_addr] = wb_data;
            end
            ref_tag[idx][vw]   = op.a[31:8];
            ref_valid[idx][vw] = 1'b1;
            ref_dirty[idx][vw] = 1'b0;
            ref_line[idx][vw]  = fl;
            hw = vw;
            @(negedge clk);
            fill_valid = 1'b0;
            cnt = 0;
            while (blocked) begin
                assert (resp_valid == 1'b0) else report_value("resp_valid", resp_valid, 0);
                @(negedge clk);
                cnt++;
                if (cnt > 8) begin
                    report_issue("timeout waiting for blocked to fall after refill");
                end
            end
            // One replay cycle between the refill and the release
            assert (cnt == 1)
                else report_issue("blocked did not fall in the cycle after the replay");
            req_valid = 1'b0;
            assert (resp_valid == !op.st) else report_value("resp_valid", resp_valid, !op.st);
            if (!op.st) begin
                assert (resp_data == ref_line[idx][hw][ws])
                    else report_value("resp_data", resp_data, ref_line[idx][hw][ws]);
            end
        end
        if (op.st) begin
            ref_line[idx][hw][ws] = op.d;
            ref_dirty[idx][hw] = 1'b1;
        end
        touch_way(idx, hw);
    endtask

    initial begin
        // Set 3 is shared by lines 0x10030 up to 0x60030
        ops = '{
            '{1'b0, 32'h0000_1000, 32'h0},
            '{1'b0, 32'h0000_1004, 32'h0},
            '{1'b1, 32'h0000_1008, 32'hCAFE_0001},
            '{1'b0, 32'h0000_1008, 32'h0},
            '{1'b1, 32'h0000_2014, 32'hBEEF_0002},
            '{1'b0, 32'h0000_2014, 32'h0},
            '{1'b0, 32'h0000_2018, 32'h0},
            '{1'b1, 32'h0001_0030, 32'h1234_5678},
            '{1'b0, 32'h0002_0030, 32'h0},
            '{1'b0, 32'h0003_0030, 32'h0},
            '{1'b0, 32'h0004_0030, 32'h0},
            '{1'b0, 32'h0005_0030, 32'h0},
            '{1'b0, 32'h0002_0034, 32'h0},
            '{1'b0, 32'h0006_0030, 32'h0},
            '{1'b0, 32'h0001_0030, 32'h0},
            '{1'b0, 32'h0001_0034, 32'h0}
        };
        for (int s = 0; s < NS; s++) begin
            for (int w = 0; w < NW; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_age[s][w]   = w;
                ref_line[s][w]  = '0;
            end
        end
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_store  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        fill_valid = 1'b0;
        fill_addr  = '0;
        fill_data  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (!blocked && !resp_valid && !l2_req_valid && !wb_valid)
            else report_issue("status outputs not low after reset");
        for (int i = 0; i < N_OPS; i++) begin
            run_op(ops[i]);
        end
        @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/cache_pkg.sv
logic/way_if.sv
logic/cache_way.sv
logic/cache_ctrl.sv
logic/way_merge.sv
logic/data_cache.sv
bench/cache_properties.sv
bench/cache_tb.sv

/* run.sh */
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module cache_tb \
    -Mdir obj_dir -o cache_sim && ./obj_dir/cache_sim > run.log 2>&1 || {
    cat run.log 2>/dev/null
    exit 1
}

cat run.log
grep -q '\*\* FAIL \*\*' run.log && exit 1
exit 0
